// ==== Makefile ====
# Verilator simulation of the playback core

VERILATOR ?= verilator
TOP       ?= ipod_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, run, and pass only if the run printed the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/ipod_pkg.sv ====
`default_nettype none

package ipod_pkg;

  // ========================================
  // Data path widths
  // ========================================

  // One audio sample
  localparam int sample_w = 16;

  // Flash data word, two samples per word
  localparam int word_w = 32;

  // Flash word address
  localparam int addr_w = 23;

  // Sample index, low bit picks the half of the word
  localparam int index_w = addr_w + 1;

  // Half-period count of the sample tick
  localparam int period_w = 16;

  // ========================================
  // Keyboard commands (ASCII)
  // ========================================
  typedef enum logic [7:0] {
    key_play     = 8'h45,  // 'E'
    key_pause    = 8'h44,  // 'D'
    key_forward  = 8'h46,  // 'F'
    key_backward = 8'h42,  // 'B'
    key_restart  = 8'h52   // 'R'
  } key_cmd_t;

  // Flash read sequence
  typedef enum logic [1:0] {
    fetch_idle,
    fetch_request,
    fetch_wait_data,
    fetch_done
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== logic/ipod_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipod_top #(
  parameter int unsigned base_half_period = 11000,
  parameter int unsigned speed_step       = 100,
  parameter int unsigned min_half_period  = 1000,
  parameter int unsigned max_half_period  = 30000,
  parameter int unsigned last_sample      = 1048575
) (
  input  wire logic                          CLK_50M,
  input  wire logic                          reset,

  // Decoded keyboard command
  input  wire logic [7:0]                    key_code,
  input  wire logic                          key_valid,

  // Debounced speed buttons
  input  wire logic                          speed_up,
  input  wire logic                          speed_down,
  input  wire logic                          speed_reset,

  // Flash read port
  output logic                               flash_read,
  output logic [ipod_pkg::addr_w-1:0]        flash_address,
  input  wire logic                          flash_waitrequest,
  input  wire logic [ipod_pkg::word_w-1:0]   flash_readdata,
  input  wire logic                          flash_readdatavalid,

  // Audio out and status
  output logic [ipod_pkg::sample_w-1:0]      sample,
  output logic                               sample_valid,
  output logic                               playing,
  output logic                               reverse
);

  logic sample_tick;
  logic latch_sample;
  logic step_index;
  logic restart_index;

  // ========================================
  // Sample rate
  // ========================================
  rate_gen #(
    .base_half_period (base_half_period),
    .speed_step       (speed_step),
    .min_half_period  (min_half_period),
    .max_half_period  (max_half_period)
  ) rate_gen_inst (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .sample_tick (sample_tick)
  );

  // ========================================
  // Key commands and read sequencing
  // ========================================
  playback_ctrl playback_ctrl_inst (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .key_code            (key_code),
    .key_valid           (key_valid),
    .sample_tick         (sample_tick),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .latch_sample        (latch_sample),
    .step_index          (step_index),
    .restart_index       (restart_index),
    .sample_valid        (sample_valid),
    .playing             (playing),
    .reverse             (reverse)
  );

  // ========================================
  // Index, address and sample select
  // ========================================
  sample_fetch #(
    .last_sample (last_sample)
  ) sample_fetch_inst (
    .CLK_50M        (CLK_50M),
    .reset          (reset),
    .latch_sample   (latch_sample),
    .step_index     (step_index),
    .restart_index  (restart_index),
    .reverse        (reverse),
    .flash_readdata (flash_readdata),
    .flash_address  (flash_address),
    .sample         (sample)
  );

endmodule

`default_nettype wire

// ==== logic/playback_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module playback_ctrl (
  input  wire logic       CLK_50M,
  input  wire logic       reset,

  input  wire logic [7:0] key_code,
  input  wire logic       key_valid,
  input  wire logic       sample_tick,

  input  wire logic       flash_waitrequest,
  input  wire logic       flash_readdatavalid,
  output logic            flash_read,

  // Strobes to the sample datapath
  output logic            latch_sample,
  output logic            step_index,
  output logic            restart_index,

  output logic            sample_valid,
  output logic            playing,
  output logic            reverse
);

  ipod_pkg::fetch_state_t state;
  ipod_pkg::fetch_state_t next_state;

  // ========================================
  // Keyboard command decode
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      playing       <= 1'b0;
      reverse       <= 1'b0;
      restart_index <= 1'b0;
    end
    else
    begin
      restart_index <= 1'b0;
      if (key_valid)
      begin
        case (key_code)
          ipod_pkg::key_play:     playing       <= 1'b1;
          ipod_pkg::key_pause:    playing       <= 1'b0;
          ipod_pkg::key_forward:  reverse       <= 1'b0;
          ipod_pkg::key_backward: reverse       <= 1'b1;
          ipod_pkg::key_restart:  restart_index <= 1'b1;
          // Anything else is not a command
          default: ;
        endcase
      end
    end
  end

  // ========================================
  // Flash read sequence
  // ========================================

  // A started fetch always runs to the end, even after a pause
  always_comb
  begin
    next_state = state;
    case (state)
      ipod_pkg::fetch_idle:
      begin
        if (sample_tick && playing)
          next_state = ipod_pkg::fetch_request;
      end
      ipod_pkg::fetch_request:
      begin
        // Hold the read until the flash takes it
        if (!flash_waitrequest)
          next_state = ipod_pkg::fetch_wait_data;
      end
      ipod_pkg::fetch_wait_data:
      begin
        if (flash_readdatavalid)
          next_state = ipod_pkg::fetch_done;
      end
      ipod_pkg::fetch_done:
      begin
        next_state = ipod_pkg::fetch_idle;
      end
      default:
      begin
        next_state = ipod_pkg::fetch_idle;
      end
    endcase
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      state <= ipod_pkg::fetch_idle;
    else
      state <= next_state;
  end

  assign flash_read   = (state == ipod_pkg::fetch_request);

  // Data word was captured in the cycle of readdatavalid
  assign latch_sample = (state == ipod_pkg::fetch_done);

  // Step and valid both trail the latch by one cycle
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      step_index   <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      step_index   <= latch_sample;
      sample_valid <= latch_sample;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rate_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module rate_gen #(
  parameter int unsigned base_half_period = 11000,
  parameter int unsigned speed_step       = 100,
  parameter int unsigned min_half_period  = 1000,
  parameter int unsigned max_half_period  = 30000
) (
  input  wire logic CLK_50M,
  input  wire logic reset,
  input  wire logic speed_up,
  input  wire logic speed_down,
  input  wire logic speed_reset,
  output logic      sample_tick
);

  localparam logic [ipod_pkg::period_w-1:0] base_v =
    base_half_period[ipod_pkg::period_w-1:0];
  localparam logic [ipod_pkg::period_w-1:0] step_v =
    speed_step[ipod_pkg::period_w-1:0];
  localparam logic [ipod_pkg::period_w-1:0] min_v =
    min_half_period[ipod_pkg::period_w-1:0];
  localparam logic [ipod_pkg::period_w-1:0] max_v =
    max_half_period[ipod_pkg::period_w-1:0];

  logic [ipod_pkg::period_w-1:0] half_period;
  logic [ipod_pkg::period_w-1:0] next_half;

  // Counts a full period, so one bit wider than the half-period
  logic [ipod_pkg::period_w:0]   count;

  // ========================================
  // Speed register with clamping
  // ========================================
  always_comb
  begin
    next_half = half_period;
    if (speed_reset)
      next_half = base_v;
    else if (speed_up)
    begin
      // Shorter period means faster playback
      if ((half_period - min_v) < step_v)
        next_half = min_v;
      else
        next_half = half_period - step_v;
    end
    else if (speed_down)
    begin
      if ((max_v - half_period) < step_v)
        next_half = max_v;
      else
        next_half = half_period + step_v;
    end
  end

  // ========================================
  // Tick divider
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      half_period <= base_v;
      count       <= {base_v, 1'b0} - 1'b1;
      sample_tick <= 1'b0;
    end
    else
    begin
      half_period <= next_half;
      sample_tick <= 1'b0;
      if (next_half != half_period)
        count <= {next_half, 1'b0} - 1'b1;
      else if (count == '0)
      begin
        count       <= {half_period, 1'b0} - 1'b1;
        sample_tick <= 1'b1;
      end
      else
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/sample_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_fetch #(
  parameter int unsigned last_sample = 1048575
) (
  input  wire logic                          CLK_50M,
  input  wire logic                          reset,

  input  wire logic                          latch_sample,
  input  wire logic                          step_index,
  input  wire logic                          restart_index,
  input  wire logic                          reverse,

  input  wire logic [ipod_pkg::word_w-1:0]   flash_readdata,
  output logic [ipod_pkg::addr_w-1:0]        flash_address,
  output logic [ipod_pkg::sample_w-1:0]      sample
);

  localparam logic [ipod_pkg::index_w-1:0] last_v =
    last_sample[ipod_pkg::index_w-1:0];

  logic [ipod_pkg::index_w-1:0] index;

  // Word seen on the flash bus one cycle ago
  logic [ipod_pkg::word_w-1:0]  word_q;

  // ========================================
  // Sample index
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      index <= '0;
    else if (restart_index)
    begin
      // Start from whichever end matches the direction
      if (reverse)
        index <= last_v;
      else
        index <= '0;
    end
    else if (step_index)
    begin
      if (reverse)
      begin
        if (index == '0)
          index <= last_v;
        else
          index <= index - 1'b1;
      end
      else
      begin
        if (index == last_v)
          index <= '0;
        else
          index <= index + 1'b1;
      end
    end
  end

  // Two samples per flash word
  assign flash_address = index[ipod_pkg::index_w-1:1];

  // ========================================
  // Half select
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    word_q <= flash_readdata;
    if (latch_sample)
    begin
      // Odd index lives in the upper half
      if (index[0])
        sample <= word_q[ipod_pkg::word_w-1:ipod_pkg::sample_w];
      else
        sample <= word_q[ipod_pkg::sample_w-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
logic/ipod_pkg.sv
logic/rate_gen.sv
logic/playback_ctrl.sv
logic/sample_fetch.sv
logic/ipod_top.sv
verification/flash_model.sv
verification/ipod_checker.sv
verification/ipod_tb.sv

// ==== verification/flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_model (
  input  wire logic                          CLK_50M,
  input  wire logic                          reset,
  input  wire logic                          read,
  input  wire logic [ipod_pkg::addr_w-1:0]   address,
  output logic                               waitrequest,
  output logic [ipod_pkg::word_w-1:0]        readdata,
  output logic                               readdatavalid
);

  logic [1:0]                    stall_left;
  logic                          pending;
  logic [1:0]                    latency_left;
  logic [ipod_pkg::addr_w-1:0]   pending_address;
  int unsigned                   latency;

  // Sample i holds its low 16 bits times 16'h1357 plus 16'h00a5, upper bits folded in
  function automatic logic [15:0] pattern(input logic [23:0] index);
    logic [15:0] product;
    product = index[15:0] * 16'h1357;
    return (product + 16'h00a5) ^ {8'h00, index[23:16]};
  endfunction

  // Even sample in the lower half, odd sample in the upper half
  function automatic logic [31:0] word_at(input logic [22:0] word_address);
    return {pattern({word_address, 1'b1}), pattern({word_address, 1'b0})};
  endfunction

  // Stall count is drawn ahead, so the stall starts with the read itself
  assign waitrequest = read && (stall_left != 2'd0);

  always @(posedge CLK_50M)
  begin
    readdatavalid <= 1'b0;
    readdata      <= $urandom;
    if (reset)
    begin
      stall_left      <= 2'($urandom_range(2, 0));
      pending         <= 1'b0;
      latency_left    <= 2'd0;
      pending_address <= '0;
    end
    else
    begin
      if (pending)
      begin
        if (latency_left == 2'd0)
        begin
          readdatavalid <= 1'b1;
          readdata      <= word_at(pending_address);
          pending       <= 1'b0;
        end
        else
          latency_left <= latency_left - 2'd1;
      end
      if (read && waitrequest)
        stall_left <= stall_left - 2'd1;
      else if (read)
      begin
        // Accepted, data follows 1 to 4 cycles later
        stall_left <= 2'($urandom_range(2, 0));
        latency = $urandom_range(4, 1);
        if (latency == 1)
        begin
          readdatavalid <= 1'b1;
          readdata      <= word_at(address);
        end
        else
        begin
          pending         <= 1'b1;
          pending_address <= address;
          latency_left    <= 2'(latency - 2);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/ipod_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipod_checker (
  input wire logic                          CLK_50M,
  input wire logic                          reset,
  input wire logic                          flash_read,
  input wire logic [ipod_pkg::addr_w-1:0]   flash_address,
  input wire logic                          flash_waitrequest,
  input wire logic                          flash_readdatavalid,
  input wire logic                          sample_valid
);

  int unsigned failures = 0;

  // ========================================
  // Flash port rules
  // ========================================

  // A stalled read holds its request and address
  stalled_read_stable: assert property (
    @(posedge CLK_50M) disable iff (reset)
    (flash_read && flash_waitrequest) |=> (flash_read && $stable(flash_address))
  )
  else
  begin
    failures++;
    $error("flash read or address changed while waitrequest was high");
  end

  // Only one read in flight
  no_read_with_data: assert property (
    @(posedge CLK_50M) disable iff (reset)
    !(flash_read && flash_readdatavalid)
  )
  else
  begin
    failures++;
    $error("flash_read high in a readdatavalid cycle");
  end

  // Audio output
  single_valid_pulse: assert property (
    @(posedge CLK_50M) disable iff (reset)
    sample_valid |=> !sample_valid
  )
  else
  begin
    failures++;
    $error("sample_valid high on two cycles in a row");
  end

endmodule

`default_nettype wire

// ==== verification/ipod_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipod_tb;

  localparam int unsigned base_half  = 20;
  localparam int unsigned step       = 4;
  localparam int unsigned min_half   = 8;
  localparam int unsigned max_half   = 40;
  localparam int unsigned last_index = 63;
  localparam int unsigned timeout    = 300;

  logic                          CLK_50M;
  logic                          reset;
  logic [7:0]                    key_code;
  logic                          key_valid;
  logic                          speed_up;
  logic                          speed_down;
  logic                          speed_reset;
  logic                          flash_read;
  logic [ipod_pkg::addr_w-1:0]   flash_address;
  logic                          flash_waitrequest;
  logic [ipod_pkg::word_w-1:0]   flash_readdata;
  logic                          flash_readdatavalid;
  logic [ipod_pkg::sample_w-1:0] sample;
  logic                          sample_valid;
  logic                          playing;
  logic                          reverse;

  // Expected playback position, direction and speed
  int unsigned next_index;
  logic        dir_reverse;
  int unsigned half_model;

  ipod_top #(
    .base_half_period (base_half),
    .speed_step       (step),
    .min_half_period  (min_half),
    .max_half_period  (max_half),
    .last_sample      (last_index)
  ) dut0 (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .key_code            (key_code),
    .key_valid           (key_valid),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid),
    .playing             (playing),
    .reverse             (reverse)
  );

  flash_model flash0 (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .read          (flash_read),
    .address       (flash_address),
    .waitrequest   (flash_waitrequest),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  bind ipod_top ipod_checker checker0 (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .sample_valid        (sample_valid)
  );

  always #10 CLK_50M = ~CLK_50M;

  // ========================================
  // Failure reporting
  // ========================================
  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
    stop_run();
  endtask

  task automatic report_problem(input string what);
    $display("%s (at %0t ns)", what, $time);
    stop_run();
  endtask

  // ========================================
  // Reference model and helpers
  // ========================================
  function automatic logic [15:0] expected_sample(input int unsigned index);
    logic [31:0] i;
    logic [15:0] product;
    i = index;
    product = i[15:0] * 16'h1357;
    return (product + 16'h00a5) ^ {8'h00, i[23:16]};
  endfunction

  function automatic int unsigned next_in_sequence(input int unsigned index,
                                                   input logic backward);
    if (backward)
      return (index == 0) ? last_index : index - 1;
    return (index == last_index) ? 0 : index + 1;
  endfunction

  // Called on a falling edge, returns one cycle later
  task automatic press_key(input logic [7:0] code);
    key_code  = code;
    key_valid = 1'b1;
    @(negedge CLK_50M);
    key_valid = 1'b0;
    key_code  = 8'h00;
  endtask

  task automatic check_sample();
    assert (sample == expected_sample(next_index))
      else report_mismatch($sformatf("sample of index %0d", next_index),
                           32'(sample), 32'(expected_sample(next_index)));
    next_index = next_in_sequence(next_index, dir_reverse);
  endtask

  task automatic wait_sample();
    int unsigned cycles;
    cycles = 0;
    @(negedge CLK_50M);
    while (!sample_valid)
    begin
      cycles++;
      if (cycles > timeout)
        report_problem("sample_valid did not arrive in time");
      @(negedge CLK_50M);
    end
    check_sample();
  endtask

  task automatic wait_read_rise(output int unsigned cycles);
    logic prev;
    logic rose;
    prev   = flash_read;
    rose   = 1'b0;
    cycles = 0;
    while (!rose)
    begin
      @(negedge CLK_50M);
      cycles++;
      if (cycles > timeout)
        report_problem("flash_read did not rise in time");
      rose = flash_read && !prev;
      prev = flash_read;
    end
  endtask

  // 0 speeds up, 1 slows down, anything else restores the base rate
  task automatic pulse_speed(input int which);
    int new_half;
    new_half = base_half;
    case (which)
      0:
      begin
        speed_up = 1'b1;
        // One step shorter, but never below the lower limit
        new_half = int'(half_model) - int'(step);
        if (new_half < int'(min_half))
          new_half = min_half;
      end
      1:
      begin
        speed_down = 1'b1;
        new_half   = half_model + step;
        if (new_half > int'(max_half))
          new_half = max_half;
      end
      default:
      begin
        speed_reset = 1'b1;
      end
    endcase
    half_model = new_half;
    @(negedge CLK_50M);
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    // Keep each press a separate strobe
    @(negedge CLK_50M);
  endtask

  // First rise may be an old tick, so the third one gives a clean interval
  task automatic check_interval();
    int unsigned gap;
    wait_read_rise(gap);
    wait_read_rise(gap);
    wait_read_rise(gap);
    assert (gap == 2 * half_model)
      else report_mismatch("flash_read interval", gap, 2 * half_model);
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic check_reset_idle();
    assert (!playing && !reverse)
      else report_mismatch("playing and reverse", {30'd0, playing, reverse}, 32'd0);
    repeat (300)
    begin
      @(negedge CLK_50M);
      assert (!flash_read && !sample_valid)
        else report_problem("flash read or sample while paused after reset");
    end
  endtask

  task automatic play_forward();
    press_key("E");
    repeat (70)
      wait_sample();
  endtask

  // Keys go in right after a sample, a full tick before the next fetch
  task automatic play_backward();
    press_key("B");
    dir_reverse = 1'b1;
    press_key("R");
    next_index = last_index;
    repeat (70)
      wait_sample();
    press_key("F");
    dir_reverse = 1'b0;
    repeat (10)
      wait_sample();
  endtask

  task automatic pause_and_resume();
    int unsigned cycles;
    int unsigned pulses;
    logic        read_prev;
    cycles = 0;
    while (!flash_read)
    begin
      cycles++;
      if (cycles > timeout)
        report_problem("no flash read started before pause");
      @(negedge CLK_50M);
    end
    // Pause with a fetch in flight
    press_key("D");
    pulses    = 0;
    read_prev = flash_read;
    repeat (200)
    begin
      @(negedge CLK_50M);
      assert (!(flash_read && !read_prev))
        else report_problem("new flash read started after pause");
      if (sample_valid)
      begin
        pulses++;
        check_sample();
      end
      read_prev = flash_read;
    end
    // The fetch in flight still delivers its sample
    assert (pulses == 1)
      else report_mismatch("samples after pause", pulses, 1);
    press_key("X");
    assert (!playing && reverse == dir_reverse)
      else report_problem("unknown key changed the paused state");
    repeat (100)
    begin
      @(negedge CLK_50M);
      assert (!flash_read)
        else report_problem("flash read after unknown key while paused");
    end
    press_key("E");
    repeat (10)
      wait_sample();
    press_key("X");
    assert (playing && reverse == dir_reverse)
      else report_problem("unknown key changed the playing state");
    repeat (5)
      wait_sample();
  endtask

  task automatic speed_control();
    check_interval();
    repeat (2)
      pulse_speed(0);
    check_interval();
    repeat (4)
      pulse_speed(0);
    check_interval();
    repeat (12)
      pulse_speed(1);
    check_interval();
    pulse_speed(2);
    check_interval();
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial
  begin
    void'($urandom(32'h80cfbfd8));
    CLK_50M     = 1'b0;
    reset       = 1'b1;
    key_code    = 8'h00;
    key_valid   = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    next_index  = 0;
    dir_reverse = 1'b0;
    half_model  = base_half;
    repeat (10)
      @(posedge CLK_50M);
    @(negedge CLK_50M);
    reset = 1'b0;

    check_reset_idle();
    play_forward();
    play_backward();
    pause_and_resume();
    speed_control();

    if (dut0.checker0.failures != 0)
      report_problem("flash port or sample_valid assertion failed");
    else
    begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
